/* src/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  // one-hot operation vectors
  typedef logic [9:0] alu_op_t;
  typedef logic [5:0] csr_op_t;
  typedef logic [3:0] mul_op_t;
  typedef logic [3:0] div_op_t;

  localparam int ALU_ADD = 0;
  localparam int ALU_SUB = 1;
  localparam int ALU_SLL = 2;
  localparam int ALU_SRL = 3;
  localparam int ALU_SRA = 4;
  localparam int ALU_SLT = 5;
  localparam int ALU_SLTU = 6;
  localparam int ALU_AND = 7;
  localparam int ALU_OR = 8;
  localparam int ALU_XOR = 9;

  localparam int CSR_RW = 0;
  localparam int CSR_RS = 1;
  localparam int CSR_RC = 2;
  localparam int CSR_RWI = 3;
  localparam int CSR_RSI = 4;
  localparam int CSR_RCI = 5;

  localparam int MUL_MUL = 0;
  localparam int MUL_MULH = 1;
  localparam int MUL_MULHSU = 2;
  localparam int MUL_MULHU = 3;

  localparam int DIV_DIV = 0;
  localparam int DIV_DIVU = 1;
  localparam int DIV_REM = 2;
  localparam int DIV_REMU = 3;

  localparam logic [6:0] OPCODE_LUI = 7'b0110111;
  localparam logic [6:0] OPCODE_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_REG = 7'b0110011;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  // base integer funct3
  localparam logic [2:0] FUNCT_ADD = 3'b000;
  localparam logic [2:0] FUNCT_SLL = 3'b001;
  localparam logic [2:0] FUNCT_SLT = 3'b010;
  localparam logic [2:0] FUNCT_SLTU = 3'b011;
  localparam logic [2:0] FUNCT_XOR = 3'b100;
  localparam logic [2:0] FUNCT_SRL = 3'b101;
  localparam logic [2:0] FUNCT_OR = 3'b110;
  localparam logic [2:0] FUNCT_AND = 3'b111;

  // M extension funct3
  localparam logic [2:0] FUNCT_MUL = 3'b000;
  localparam logic [2:0] FUNCT_MULH = 3'b001;
  localparam logic [2:0] FUNCT_MULHSU = 3'b010;
  localparam logic [2:0] FUNCT_MULHU = 3'b011;
  localparam logic [2:0] FUNCT_DIV = 3'b100;
  localparam logic [2:0] FUNCT_DIVU = 3'b101;
  localparam logic [2:0] FUNCT_REM = 3'b110;
  localparam logic [2:0] FUNCT_REMU = 3'b111;

  // system funct3
  localparam logic [2:0] FUNCT_PRIV = 3'b000;
  localparam logic [2:0] FUNCT_CSRRW = 3'b001;
  localparam logic [2:0] FUNCT_CSRRS = 3'b010;
  localparam logic [2:0] FUNCT_CSRRC = 3'b011;
  localparam logic [2:0] FUNCT_CSRRWI = 3'b101;
  localparam logic [2:0] FUNCT_CSRRSI = 3'b110;
  localparam logic [2:0] FUNCT_CSRRCI = 3'b111;

  localparam csr_addr_t CSR_ECALL = 12'h000;
  localparam csr_addr_t CSR_EBREAK = 12'h001;
  localparam csr_addr_t CSR_MRET = 12'h302;
  localparam csr_addr_t CSR_WFI = 12'h105;

  // addi x0,x0,0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

  localparam logic [3:0] ADDR_INSTR = 4'h0;
  localparam logic [3:0] ADDR_STATUS = 4'h4;
  localparam logic [3:0] ADDR_ILLEGAL = 4'h8;

endpackage

`default_nettype wire

/* src/apb_instr_port.sv */
`default_nettype none

module apb_instr_port #(
  parameter int FIFO_DEPTH = 4
) (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic psel,
  input wire logic penable,
  input wire logic pwrite,
  input wire logic [3:0] paddr,
  input wire rv_decode_pkg::word_t pwdata,
  output rv_decode_pkg::word_t prdata,
  output logic pready,
  output logic pslverr,
  output logic push,
  output rv_decode_pkg::instr_t push_data,
  input wire logic full,
  input wire logic [$clog2(FIFO_DEPTH):0] count,
  input wire rv_decode_pkg::word_t illegal_count
);
  import rv_decode_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  logic setup;
  logic access;
  logic wr_instr;
  logic rd_mapped;
  word_t status;

  assign setup = psel & ~penable;
  assign access = psel & penable;

  assign wr_instr = pwrite & (paddr == ADDR_INSTR);
  // the instruction register is write-only
  assign rd_mapped = ~pwrite & ((paddr == ADDR_STATUS) | (paddr == ADDR_ILLEGAL));

  // zero wait states, every transfer ends in its first access cycle
  assign pready = 1'b1;

  assign push = access & wr_instr & ~full;
  assign push_data = pwdata;

  // a write into a full FIFO is dropped and flagged
  assign pslverr = access & ~(wr_instr & ~full) & ~rd_mapped;

  assign status = {full, {(31 - CNT_W){1'b0}}, count};

  // read data is taken in the setup phase so it is on the bus for the access phase
  always_ff @(posedge clk) begin
    if (setup && !pwrite) begin
      case (paddr)
        ADDR_STATUS: prdata <= status;
        ADDR_ILLEGAL: prdata <= illegal_count;
        default: prdata <= '0;
      endcase
    end
  end

  property p_push_one_cycle;
    @(posedge clk) disable iff (!rst_n) push |=> !push;
  endproperty

  a_push_one_cycle: assert property (p_push_one_cycle)
    else $error("push held for more than one cycle");

endmodule

`default_nettype wire

/* src/instr_fifo.sv */
`default_nettype none

module instr_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic push,
  input wire rv_decode_pkg::instr_t push_data,
  input wire logic pop,
  output rv_decode_pkg::instr_t pop_data,
  output logic full,
  output logic empty,
  output logic [$clog2(FIFO_DEPTH):0] count
);
  import rv_decode_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  instr_t mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // head word shown before the pop
  assign pop_data = mem[rd_ptr];

  assign full = (count == (AW + 1)'(FIFO_DEPTH));
  assign empty = (count == '0);

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
    else $error("push into full FIFO");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
    else $error("pop from empty FIFO");

endmodule

`default_nettype wire

/* src/postdecoder.sv */
`default_nettype none

module postdecoder (
  input wire rv_decode_pkg::instr_t instr,
  output rv_decode_pkg::word_t imm,
  output logic wren,
  output logic rden1,
  output logic rden2,
  output logic cwren,
  output logic crden,
  output logic lui,
  output logic nop,
  output logic csrreg,
  output logic division,
  output logic mult,
  output rv_decode_pkg::alu_op_t alu_op,
  output rv_decode_pkg::csr_op_t csr_op,
  output rv_decode_pkg::div_op_t div_op,
  output rv_decode_pkg::mul_op_t mul_op,
  output logic ecall,
  output logic ebreak,
  output logic mret,
  output logic wfi,
  output logic legal
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_addr_t rd;
  reg_addr_t rs1;
  csr_addr_t csr_field;
  word_t imm_c;
  word_t imm_i;
  word_t imm_u;
  logic rd_nz;
  logic rs1_nz;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd = instr[11:7];
  assign rs1 = instr[19:15];
  assign csr_field = instr[31:20];

  // csr uimm lives in the rs1 field
  assign imm_c = {27'h0, rs1};
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'h0};

  assign rd_nz = |rd;
  // also covers the uimm of the immediate csr forms
  assign rs1_nz = |rs1;

  always_comb begin
    imm = '0;
    wren = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    cwren = 1'b0;
    crden = 1'b0;
    lui = 1'b0;
    nop = 1'b0;
    csrreg = 1'b0;
    division = 1'b0;
    mult = 1'b0;
    alu_op = '0;
    csr_op = '0;
    div_op = '0;
    mul_op = '0;
    ecall = 1'b0;
    ebreak = 1'b0;
    mret = 1'b0;
    wfi = 1'b0;
    legal = 1'b1;

    case (opcode)
      OPCODE_LUI: begin
        imm = imm_u;
        wren = rd_nz;
        lui = 1'b1;
      end
      OPCODE_IMM: begin
        imm = imm_i;
        wren = rd_nz;
        rden1 = 1'b1;
        case (funct3)
          FUNCT_ADD: alu_op[ALU_ADD] = 1'b1;
          FUNCT_SLL: begin
            alu_op[ALU_SLL] = 1'b1;
            legal = ~instr[25];
          end
          FUNCT_SRL: begin
            alu_op[ALU_SRL] = ~instr[30];
            alu_op[ALU_SRA] = instr[30];
            legal = ~instr[25];
          end
          FUNCT_SLT: alu_op[ALU_SLT] = 1'b1;
          FUNCT_SLTU: alu_op[ALU_SLTU] = 1'b1;
          FUNCT_AND: alu_op[ALU_AND] = 1'b1;
          FUNCT_OR: alu_op[ALU_OR] = 1'b1;
          FUNCT_XOR: alu_op[ALU_XOR] = 1'b1;
        endcase
      end
      OPCODE_REG: begin
        wren = rd_nz;
        rden1 = 1'b1;
        rden2 = 1'b1;
        if (!instr[25]) begin
          case (funct3)
            FUNCT_ADD: begin
              alu_op[ALU_ADD] = ~instr[30];
              alu_op[ALU_SUB] = instr[30];
            end
            FUNCT_SLL: alu_op[ALU_SLL] = 1'b1;
            FUNCT_SRL: begin
              alu_op[ALU_SRL] = ~instr[30];
              alu_op[ALU_SRA] = instr[30];
            end
            FUNCT_SLT: alu_op[ALU_SLT] = 1'b1;
            FUNCT_SLTU: alu_op[ALU_SLTU] = 1'b1;
            FUNCT_AND: alu_op[ALU_AND] = 1'b1;
            FUNCT_OR: alu_op[ALU_OR] = 1'b1;
            FUNCT_XOR: alu_op[ALU_XOR] = 1'b1;
          endcase
        end else begin
          // M extension
          mult = ~funct3[2];
          division = funct3[2];
          case (funct3)
            FUNCT_MUL: mul_op[MUL_MUL] = 1'b1;
            FUNCT_MULH: mul_op[MUL_MULH] = 1'b1;
            FUNCT_MULHSU: mul_op[MUL_MULHSU] = 1'b1;
            FUNCT_MULHU: mul_op[MUL_MULHU] = 1'b1;
            FUNCT_DIV: div_op[DIV_DIV] = 1'b1;
            FUNCT_DIVU: div_op[DIV_DIVU] = 1'b1;
            FUNCT_REM: div_op[DIV_REM] = 1'b1;
            FUNCT_REMU: div_op[DIV_REMU] = 1'b1;
          endcase
        end
      end
      OPCODE_SYSTEM: begin
        imm = imm_c;
        csrreg = (funct3 != FUNCT_PRIV) & (funct3 != 3'b100);
        if (csrreg) begin
          wren = rd_nz;
          rden1 = ~funct3[2];
        end
        case (funct3)
          FUNCT_PRIV: begin
            case (csr_field)
              CSR_ECALL: ecall = 1'b1;
              CSR_EBREAK: ebreak = 1'b1;
              CSR_MRET: mret = 1'b1;
              CSR_WFI: wfi = 1'b1;
              default: legal = 1'b0;
            endcase
          end
          // swap forms skip the csr read when rd is x0
          FUNCT_CSRRW: begin
            cwren = 1'b1;
            crden = rd_nz;
            csr_op[CSR_RW] = 1'b1;
          end
          FUNCT_CSRRWI: begin
            cwren = 1'b1;
            crden = rd_nz;
            csr_op[CSR_RWI] = 1'b1;
          end
          // set and clear forms skip the csr write when the mask is zero
          FUNCT_CSRRS: begin
            cwren = rs1_nz;
            crden = 1'b1;
            csr_op[CSR_RS] = 1'b1;
          end
          FUNCT_CSRRC: begin
            cwren = rs1_nz;
            crden = 1'b1;
            csr_op[CSR_RC] = 1'b1;
          end
          FUNCT_CSRRSI: begin
            cwren = rs1_nz;
            crden = 1'b1;
            csr_op[CSR_RSI] = 1'b1;
          end
          FUNCT_CSRRCI: begin
            cwren = rs1_nz;
            crden = 1'b1;
            csr_op[CSR_RCI] = 1'b1;
          end
          // funct3 4 is reserved
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase

    if (instr == NOP_INSTR) begin
      alu_op[ALU_ADD] = 1'b0;
      nop = 1'b1;
    end
  end

  always_comb begin
    a_alu_onehot: assert ($onehot0(alu_op)) else $error("alu_op not one-hot");
    a_csr_onehot: assert ($onehot0(csr_op)) else $error("csr_op not one-hot");
    a_mul_onehot: assert ($onehot0(mul_op)) else $error("mul_op not one-hot");
    a_div_onehot: assert ($onehot0(div_op)) else $error("div_op not one-hot");
  end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage (
  input wire logic clk,
  input wire logic rst_n,
  input wire rv_decode_pkg::instr_t pop_data,
  input wire logic empty,
  output logic pop,
  output logic dec_valid,
  input wire logic dec_ready,
  output rv_decode_pkg::word_t dec_imm,
  output logic dec_wren,
  output logic dec_rden1,
  output logic dec_rden2,
  output logic dec_cwren,
  output logic dec_crden,
  output logic dec_lui,
  output logic dec_nop,
  output logic dec_csrreg,
  output logic dec_division,
  output logic dec_mult,
  output rv_decode_pkg::alu_op_t dec_alu_op,
  output rv_decode_pkg::csr_op_t dec_csr_op,
  output rv_decode_pkg::div_op_t dec_div_op,
  output rv_decode_pkg::mul_op_t dec_mul_op,
  output logic dec_ecall,
  output logic dec_ebreak,
  output logic dec_mret,
  output logic dec_wfi,
  output logic dec_legal,
  output rv_decode_pkg::reg_addr_t dec_rd,
  output rv_decode_pkg::reg_addr_t dec_rs1,
  output rv_decode_pkg::reg_addr_t dec_rs2,
  output rv_decode_pkg::csr_addr_t dec_csr_addr,
  output rv_decode_pkg::word_t illegal_count
);
  import rv_decode_pkg::*;

  word_t pd_imm;
  logic pd_wren;
  logic pd_rden1;
  logic pd_rden2;
  logic pd_cwren;
  logic pd_crden;
  logic pd_lui;
  logic pd_nop;
  logic pd_csrreg;
  logic pd_division;
  logic pd_mult;
  alu_op_t pd_alu_op;
  csr_op_t pd_csr_op;
  div_op_t pd_div_op;
  mul_op_t pd_mul_op;
  logic pd_ecall;
  logic pd_ebreak;
  logic pd_mret;
  logic pd_wfi;
  logic pd_legal;

  postdecoder u_postdec (
    .instr(pop_data),
    .imm(pd_imm),
    .wren(pd_wren),
    .rden1(pd_rden1),
    .rden2(pd_rden2),
    .cwren(pd_cwren),
    .crden(pd_crden),
    .lui(pd_lui),
    .nop(pd_nop),
    .csrreg(pd_csrreg),
    .division(pd_division),
    .mult(pd_mult),
    .alu_op(pd_alu_op),
    .csr_op(pd_csr_op),
    .div_op(pd_div_op),
    .mul_op(pd_mul_op),
    .ecall(pd_ecall),
    .ebreak(pd_ebreak),
    .mret(pd_mret),
    .wfi(pd_wfi),
    .legal(pd_legal)
  );

  // take a word when the output register is empty or drains this cycle
  assign pop = ~empty & (~dec_valid | dec_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      illegal_count <= '0;
    end else begin
      if (pop) begin
        dec_valid <= 1'b1;
      end else if (dec_ready) begin
        dec_valid <= 1'b0;
      end
      if (pop && !pd_legal) begin
        illegal_count <= illegal_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      dec_imm <= pd_imm;
      dec_wren <= pd_wren;
      dec_rden1 <= pd_rden1;
      dec_rden2 <= pd_rden2;
      dec_cwren <= pd_cwren;
      dec_crden <= pd_crden;
      dec_lui <= pd_lui;
      dec_nop <= pd_nop;
      dec_csrreg <= pd_csrreg;
      dec_division <= pd_division;
      dec_mult <= pd_mult;
      dec_alu_op <= pd_alu_op;
      dec_csr_op <= pd_csr_op;
      dec_div_op <= pd_div_op;
      dec_mul_op <= pd_mul_op;
      dec_ecall <= pd_ecall;
      dec_ebreak <= pd_ebreak;
      dec_mret <= pd_mret;
      dec_wfi <= pd_wfi;
      dec_legal <= pd_legal;
      dec_rd <= pop_data[11:7];
      dec_rs1 <= pop_data[19:15];
      dec_rs2 <= pop_data[24:20];
      dec_csr_addr <= pop_data[31:20];
    end
  end

  // a stalled result stays valid and unchanged until it is taken
  property p_hold_under_stall;
    @(posedge clk) disable iff (!rst_n)
      dec_valid && !dec_ready |=> dec_valid && $stable({dec_imm, dec_wren, dec_rden1,
        dec_rden2, dec_cwren, dec_crden, dec_lui, dec_nop, dec_csrreg, dec_division,
        dec_mult, dec_alu_op, dec_csr_op, dec_div_op, dec_mul_op, dec_ecall, dec_ebreak,
        dec_mret, dec_wfi, dec_legal, dec_rd, dec_rs1, dec_rs2, dec_csr_addr});
  endproperty

  a_hold_under_stall: assert property (p_hold_under_stall)
    else $error("decode output changed while stalled");

endmodule

`default_nettype wire

/* src/decode_top.sv */
`default_nettype none

module decode_top #(
  parameter int FIFO_DEPTH = 4
) (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic psel,
  input wire logic penable,
  input wire logic pwrite,
  input wire logic [3:0] paddr,
  input wire rv_decode_pkg::word_t pwdata,
  output rv_decode_pkg::word_t prdata,
  output logic pready,
  output logic pslverr,
  input wire logic dec_ready,
  output logic dec_valid,
  output rv_decode_pkg::word_t dec_imm,
  output logic dec_wren,
  output logic dec_rden1,
  output logic dec_rden2,
  output logic dec_cwren,
  output logic dec_crden,
  output logic dec_lui,
  output logic dec_nop,
  output logic dec_csrreg,
  output logic dec_division,
  output logic dec_mult,
  output rv_decode_pkg::alu_op_t dec_alu_op,
  output rv_decode_pkg::csr_op_t dec_csr_op,
  output rv_decode_pkg::div_op_t dec_div_op,
  output rv_decode_pkg::mul_op_t dec_mul_op,
  output logic dec_ecall,
  output logic dec_ebreak,
  output logic dec_mret,
  output logic dec_wfi,
  output logic dec_legal,
  output rv_decode_pkg::reg_addr_t dec_rd,
  output rv_decode_pkg::reg_addr_t dec_rs1,
  output rv_decode_pkg::reg_addr_t dec_rs2,
  output rv_decode_pkg::csr_addr_t dec_csr_addr
);
  import rv_decode_pkg::*;

  logic push;
  instr_t push_data;
  logic pop;
  instr_t pop_data;
  logic full;
  logic empty;
  logic [$clog2(FIFO_DEPTH):0] count;
  word_t illegal_count;

  // all three blocks share the same signal names, so ports connect by name
  apb_instr_port #(.FIFO_DEPTH(FIFO_DEPTH)) u_port (.*);

  instr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (.*);

  decode_stage u_stage (.*);

endmodule

`default_nettype wire

/* tests/tb_decode_top.sv */
`default_nettype none

module tb_decode_top;
  import rv_decode_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int RESULT_TIMEOUT = 20;

  // expected decode of one instruction word
  typedef struct packed {
    word_t imm;
    logic wren, rden1, rden2, cwren, crden;
    logic lui, nop, csrreg, division, mult;
    alu_op_t alu_op;
    csr_op_t csr_op;
    div_op_t div_op;
    mul_op_t mul_op;
    logic ecall, ebreak, mret, wfi, legal;
    reg_addr_t rd, rs1, rs2;
    csr_addr_t csr_addr;
  } dec_exp_t;

  logic clk;
  logic rst_n;
  logic psel;
  logic penable;
  logic pwrite;
  logic [3:0] paddr;
  word_t pwdata;
  word_t prdata;
  logic pready;
  logic pslverr;
  logic dec_ready;
  logic dec_valid;
  word_t dec_imm;
  logic dec_wren;
  logic dec_rden1;
  logic dec_rden2;
  logic dec_cwren;
  logic dec_crden;
  logic dec_lui;
  logic dec_nop;
  logic dec_csrreg;
  logic dec_division;
  logic dec_mult;
  alu_op_t dec_alu_op;
  csr_op_t dec_csr_op;
  div_op_t dec_div_op;
  mul_op_t dec_mul_op;
  logic dec_ecall;
  logic dec_ebreak;
  logic dec_mret;
  logic dec_wfi;
  logic dec_legal;
  reg_addr_t dec_rd;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  csr_addr_t dec_csr_addr;

  int illegal_sent;

  decode_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_alu(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_csr(input string name, input csr_op_t got, input csr_op_t exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_mul(input string name, input mul_op_t got, input mul_op_t exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_div(input string name, input div_op_t got, input div_op_t exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_csr_addr(input string name, input csr_addr_t got, input csr_addr_t exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  function automatic instr_t encode_r(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_REG};
  endfunction

  function automatic instr_t encode_i(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPCODE_IMM};
  endfunction

  function automatic instr_t encode_sys(input csr_addr_t csr, input reg_addr_t rs1,
                                        input logic [2:0] f3, input reg_addr_t rd);
    return {csr, rs1, f3, rd, OPCODE_SYSTEM};
  endfunction

  function automatic reg_addr_t rand_reg_nz();
    return 5'(1 + ($urandom % 31));
  endfunction

  // alt picks sub for add and sra for srl
  function automatic alu_op_t base_alu(input logic [2:0] f3, input logic alt);
    alu_op_t a;
    a = '0;
    case (f3)
      FUNCT_ADD: a[alt ? ALU_SUB : ALU_ADD] = 1'b1;
      FUNCT_SLL: a[ALU_SLL] = 1'b1;
      FUNCT_SLT: a[ALU_SLT] = 1'b1;
      FUNCT_SLTU: a[ALU_SLTU] = 1'b1;
      FUNCT_XOR: a[ALU_XOR] = 1'b1;
      FUNCT_SRL: a[alt ? ALU_SRA : ALU_SRL] = 1'b1;
      FUNCT_OR: a[ALU_OR] = 1'b1;
      default: a[ALU_AND] = 1'b1;
    endcase
    return a;
  endfunction

  function automatic dec_exp_t ref_decode(input instr_t w);
    dec_exp_t e;
    logic [6:0] opc;
    logic [2:0] f3;
    opc = w[6:0];
    f3 = w[14:12];
    e = '0;
    e.legal = 1'b1;
    e.rd = w[11:7];
    e.rs1 = w[19:15];
    e.rs2 = w[24:20];
    e.csr_addr = w[31:20];
    if (opc == OPCODE_LUI) begin
      e.lui = 1'b1;
      e.imm = {w[31:12], 12'h000};
      e.wren = (e.rd != 5'd0);
    end else if (opc == OPCODE_IMM) begin
      e.imm = {{20{w[31]}}, w[31:20]};
      e.wren = (e.rd != 5'd0);
      e.rden1 = 1'b1;
      e.alu_op = base_alu(f3, (f3 == FUNCT_SRL) && w[30]);
      // shift amounts above 31 are not valid on rv32
      if ((f3 == FUNCT_SLL || f3 == FUNCT_SRL) && w[25]) begin
        e.legal = 1'b0;
      end
    end else if (opc == OPCODE_REG) begin
      e.wren = (e.rd != 5'd0);
      e.rden1 = 1'b1;
      e.rden2 = 1'b1;
      if (!w[25]) begin
        e.alu_op = base_alu(f3, w[30]);
      end else begin
        case (f3)
          FUNCT_MUL: e.mul_op[MUL_MUL] = 1'b1;
          FUNCT_MULH: e.mul_op[MUL_MULH] = 1'b1;
          FUNCT_MULHSU: e.mul_op[MUL_MULHSU] = 1'b1;
          FUNCT_MULHU: e.mul_op[MUL_MULHU] = 1'b1;
          FUNCT_DIV: e.div_op[DIV_DIV] = 1'b1;
          FUNCT_DIVU: e.div_op[DIV_DIVU] = 1'b1;
          FUNCT_REM: e.div_op[DIV_REM] = 1'b1;
          default: e.div_op[DIV_REMU] = 1'b1;
        endcase
        e.mult = (e.mul_op != '0);
        e.division = (e.div_op != '0);
      end
    end else if (opc == OPCODE_SYSTEM) begin
      e.imm = {27'h0, w[19:15]};
      if (f3 == FUNCT_PRIV) begin
        e.ecall = (e.csr_addr == CSR_ECALL);
        e.ebreak = (e.csr_addr == CSR_EBREAK);
        e.mret = (e.csr_addr == CSR_MRET);
        e.wfi = (e.csr_addr == CSR_WFI);
        e.legal = e.ecall | e.ebreak | e.mret | e.wfi;
      end else if (f3 == 3'b100) begin
        e.legal = 1'b0;
      end else begin
        e.csrreg = 1'b1;
        e.wren = (e.rd != 5'd0);
        // only the register forms take a source register
        e.rden1 = (f3 == FUNCT_CSRRW) || (f3 == FUNCT_CSRRS) || (f3 == FUNCT_CSRRC);
        if (f3 == FUNCT_CSRRW || f3 == FUNCT_CSRRWI) begin
          e.cwren = 1'b1;
          e.crden = (e.rd != 5'd0);
        end else begin
          e.cwren = (e.rs1 != 5'd0);
          e.crden = 1'b1;
        end
        case (f3)
          FUNCT_CSRRW: e.csr_op[CSR_RW] = 1'b1;
          FUNCT_CSRRS: e.csr_op[CSR_RS] = 1'b1;
          FUNCT_CSRRC: e.csr_op[CSR_RC] = 1'b1;
          FUNCT_CSRRWI: e.csr_op[CSR_RWI] = 1'b1;
          FUNCT_CSRRSI: e.csr_op[CSR_RSI] = 1'b1;
          default: e.csr_op[CSR_RCI] = 1'b1;
        endcase
      end
    end else begin
      e.legal = 1'b0;
    end
    if (w == NOP_INSTR) begin
      e.nop = 1'b1;
      e.alu_op = '0;
    end
    return e;
  endfunction

  // one zero-wait transfer, sampled mid access cycle
  task automatic apb_write(input logic [3:0] addr, input word_t data, output logic err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #10;
    penable = 1'b1;
    #40;
    check_bit("pready", pready, 1'b1);
    err = pslverr;
    @(posedge clk);
    #10;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output word_t data, output logic err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk);
    #10;
    penable = 1'b1;
    #40;
    check_bit("pready", pready, 1'b1);
    data = prdata;
    err = pslverr;
    @(posedge clk);
    #10;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, input string name, input word_t exp);
    word_t data;
    logic err;
    apb_read(addr, data, err);
    check_bit("pslverr", err, 1'b0);
    check_word(name, data, exp);
  endtask

  task automatic push_word(input instr_t w);
    logic err;
    apb_write(ADDR_INSTR, w, err);
    check_bit("pslverr", err, 1'b0);
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    while (!dec_valid) begin
      if (n == RESULT_TIMEOUT) begin
        report_fail("timeout while waiting for a decode result");
      end
      @(posedge clk);
      #10;
      n++;
    end
  endtask

  task automatic take_result();
    dec_ready = 1'b1;
    @(posedge clk);
    #10;
    dec_ready = 1'b0;
  endtask

  task automatic check_result(input instr_t w);
    dec_exp_t e;
    e = ref_decode(w);
    check_bit("dec_valid", dec_valid, 1'b1);
    check_word("dec_imm", dec_imm, e.imm);
    check_bit("dec_wren", dec_wren, e.wren);
    check_bit("dec_rden1", dec_rden1, e.rden1);
    check_bit("dec_rden2", dec_rden2, e.rden2);
    check_bit("dec_cwren", dec_cwren, e.cwren);
    check_bit("dec_crden", dec_crden, e.crden);
    check_bit("dec_lui", dec_lui, e.lui);
    check_bit("dec_nop", dec_nop, e.nop);
    check_bit("dec_csrreg", dec_csrreg, e.csrreg);
    check_bit("dec_division", dec_division, e.division);
    check_bit("dec_mult", dec_mult, e.mult);
    check_alu("dec_alu_op", dec_alu_op, e.alu_op);
    check_csr("dec_csr_op", dec_csr_op, e.csr_op);
    check_div("dec_div_op", dec_div_op, e.div_op);
    check_mul("dec_mul_op", dec_mul_op, e.mul_op);
    check_bit("dec_ecall", dec_ecall, e.ecall);
    check_bit("dec_ebreak", dec_ebreak, e.ebreak);
    check_bit("dec_mret", dec_mret, e.mret);
    check_bit("dec_wfi", dec_wfi, e.wfi);
    check_bit("dec_legal", dec_legal, e.legal);
    check_reg("dec_rd", dec_rd, e.rd);
    check_reg("dec_rs1", dec_rs1, e.rs1);
    check_reg("dec_rs2", dec_rs2, e.rs2);
    check_csr_addr("dec_csr_addr", dec_csr_addr, e.csr_addr);
  endtask

  task automatic send_and_check(input instr_t w);
    dec_exp_t e;
    e = ref_decode(w);
    push_word(w);
    wait_result();
    check_result(w);
    if (!e.legal) begin
      illegal_sent++;
    end
    take_result();
  endtask

  task automatic reset_state();
    check_bit("dec_valid", dec_valid, 1'b0);
    read_reg(ADDR_STATUS, "status", 32'h0);
    read_reg(ADDR_ILLEGAL, "illegal_count", 32'h0);
  endtask

  task automatic base_integer_ops();
    logic [11:0] imm;
    logic [6:0] f7;
    reg_addr_t rd;
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 4; k++) begin
        rd = (k == 0) ? 5'd0 : 5'($urandom);
        imm = 12'($urandom);
        if (3'(i) == FUNCT_SLL) begin
          imm[11:5] = 7'h00;
        end
        if (3'(i) == FUNCT_SRL) begin
          imm[11:5] = k[0] ? 7'h20 : 7'h00;
        end
        send_and_check(encode_i(imm, 5'($urandom), 3'(i), rd));
        f7 = ((3'(i) == FUNCT_ADD || 3'(i) == FUNCT_SRL) && k[0]) ? 7'h20 : 7'h00;
        send_and_check(encode_r(f7, 5'($urandom), 5'($urandom), 3'(i), rd));
      end
    end
    for (int k = 0; k < 4; k++) begin
      rd = (k == 0) ? 5'd0 : 5'($urandom);
      send_and_check({20'($urandom), rd, OPCODE_LUI});
    end
  endtask

  task automatic m_ext_and_system();
    reg_addr_t rd;
    reg_addr_t rs1;
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 2; k++) begin
        rd = (k == 0) ? 5'd0 : rand_reg_nz();
        send_and_check(encode_r(7'h01, 5'($urandom), 5'($urandom), 3'(i), rd));
      end
    end
    send_and_check(encode_sys(CSR_ECALL, 5'd0, FUNCT_PRIV, 5'd0));
    send_and_check(encode_sys(CSR_EBREAK, 5'd0, FUNCT_PRIV, 5'd0));
    send_and_check(encode_sys(CSR_MRET, 5'd0, FUNCT_PRIV, 5'd0));
    send_and_check(encode_sys(CSR_WFI, 5'd0, FUNCT_PRIV, 5'd0));
    // every csr form with rd and rs1 each zero and nonzero
    for (int i = 1; i < 8; i++) begin
      if (i != 4) begin
        for (int k = 0; k < 4; k++) begin
          rd = k[0] ? rand_reg_nz() : 5'd0;
          rs1 = k[1] ? rand_reg_nz() : 5'd0;
          send_and_check(encode_sys(12'($urandom), rs1, 3'(i), rd));
        end
      end
    end
    push_word(NOP_INSTR);
    wait_result();
    check_result(NOP_INSTR);
    check_bit("dec_nop", dec_nop, 1'b1);
    check_alu("dec_alu_op", dec_alu_op, '0);
    take_result();
  endtask

  task automatic illegal_words();
    send_and_check(32'h0000_2003);
    send_and_check(32'h0000_2023);
    send_and_check(32'h0000_006f);
    send_and_check(32'h0000_0063);
    send_and_check(encode_sys(12'($urandom), 5'($urandom), 3'b100, 5'($urandom)));
    send_and_check(encode_sys(12'h7ff, 5'd0, FUNCT_PRIV, 5'd0));
    // shift immediates with bit 25 set
    send_and_check(encode_i(12'h021, rand_reg_nz(), FUNCT_SLL, rand_reg_nz()));
    send_and_check(encode_i(12'h025, rand_reg_nz(), FUNCT_SRL, rand_reg_nz()));
    send_and_check(encode_i(12'h425, rand_reg_nz(), FUNCT_SRL, rand_reg_nz()));
    read_reg(ADDR_ILLEGAL, "illegal_count", word_t'(illegal_sent));
  endtask

  task automatic back_pressure();
    instr_t sent[$];
    instr_t w;
    logic err;
    dec_ready = 1'b0;
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      w = encode_i(12'($urandom), 5'($urandom), FUNCT_ADD, rand_reg_nz());
      sent.push_back(w);
      push_word(w);
    end
    read_reg(ADDR_STATUS, "status", 32'h8000_0000 | word_t'(FIFO_DEPTH));
    apb_write(ADDR_INSTR, encode_i(12'h7ff, 5'd1, FUNCT_XOR, 5'd2), err);
    check_bit("pslverr", err, 1'b1);
    foreach (sent[i]) begin
      wait_result();
      check_result(sent[i]);
      // stalled output must not move
      repeat (2) begin
        @(posedge clk);
        #10;
      end
      check_result(sent[i]);
      take_result();
    end
    check_bit("dec_valid", dec_valid, 1'b0);
    read_reg(ADDR_STATUS, "status", 32'h0);
    check_bit("dec_valid", dec_valid, 1'b0);
  endtask

  task automatic unmapped_access();
    instr_t w;
    word_t data;
    logic err;
    w = encode_r(7'h20, rand_reg_nz(), rand_reg_nz(), FUNCT_ADD, rand_reg_nz());
    push_word(w);
    wait_result();
    apb_write(4'hc, 32'h0000_0013, err);
    check_bit("pslverr", err, 1'b1);
    apb_read(4'hc, data, err);
    check_bit("pslverr", err, 1'b1);
    apb_write(ADDR_STATUS, 32'h0000_0013, err);
    check_bit("pslverr", err, 1'b1);
    // the instruction register is write-only
    apb_read(ADDR_INSTR, data, err);
    check_bit("pslverr", err, 1'b1);
    read_reg(ADDR_STATUS, "status", 32'h0);
    check_result(w);
    take_result();
    check_bit("dec_valid", dec_valid, 1'b0);
  endtask

  initial begin
    void'($urandom(32'hec4b));
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    dec_ready = 1'b0;
    illegal_sent = 0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;

    reset_state();
    base_integer_ops();
    m_ext_and_system();
    illegal_words();
    back_pressure();
    unmapped_access();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/rv_decode_pkg.sv
src/apb_instr_port.sv
src/instr_fifo.sv
src/postdecoder.sv
src/decode_stage.sv
src/decode_top.sv
tests/tb_decode_top.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f filelist.f \
		--top-module tb_decode_top -Mdir obj_dir
	./obj_dir/Vtb_decode_top > sim.log 2>&1; cat sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "sim passed" sim.log; then echo "simulation did not finish"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module tb_decode_top

clean:
	rm -rf obj_dir sim.log
